// ==== eeprom_settings.svh ====
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// word address, 2 KB array
`define EE_ADDR_W 11

`define EE_DATA_W 8

// CLK cycles per SCL half period, keep it even
`define EE_SCL_HALF 4

// upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

`endif

// ==== eeprom_pkg.sv ====
`include "eeprom_settings.svh"

package eeprom_pkg;

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } eeprom_op_t;

    typedef struct packed
    {
        eeprom_op_t            op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] wdata;
    } eeprom_cmd_t;

    typedef enum logic [1:0]
    {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_t;

    typedef struct packed
    {
        bit_op_t               op;
        logic [`EE_DATA_W-1:0] data;
        logic                  ack_out;  // 1 = master answers nack
    } bit_req_t;

    typedef struct packed
    {
        logic [`EE_DATA_W-1:0] data;
        logic                  nack_in;  // slave ack bit after a byte out
    } bit_rsp_t;

    // busy lands in bit 0 of STATUS
    typedef struct packed
    {
        logic nack;
        logic done;
        logic busy;
    } eeprom_status_t;

endpackage

// ==== eeprom_apb_regs.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_apb_regs
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic [4:0]                 paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       busy,
    input  eeprom_pkg::eeprom_status_t status,
    input  logic [`EE_DATA_W-1:0]      rdata,
    output logic                       cmd_valid,
    output eeprom_pkg::eeprom_cmd_t    cmd
);

    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_WDATA  = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_STATUS = 5'h0C;
    localparam logic [4:0] REG_RDATA  = 5'h10;

    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic                  wr_acc;
    logic                  cmd_wr;
    logic                  cmd_known;

    assign wr_acc    = psel && penable && pwrite;
    assign cmd_wr    = wr_acc && (paddr == REG_CMD);
    assign cmd_known = (pwdata == 32'd1) || (pwdata == 32'd2);

    assign pready    = 1'b1;  // no wait states
    assign pslverr   = cmd_wr && busy;
    assign cmd_valid = cmd_wr && cmd_known && !busy;

    always_comb
    begin
        cmd.op    = pwdata[1] ? eeprom_pkg::OP_READ : eeprom_pkg::OP_WRITE;
        cmd.addr  = addr_q;
        cmd.wdata = wdata_q;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr_q  <= '0;
            wdata_q <= '0;
        end
        else if (wr_acc)
        begin
            if (paddr == REG_ADDR)
                addr_q <= pwdata[`EE_ADDR_W-1:0];
            if (paddr == REG_WDATA)
                wdata_q <= pwdata[`EE_DATA_W-1:0];
        end
    end

    // read mux, unmapped offsets give zero
    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_ADDR:
            begin
                prdata[`EE_ADDR_W-1:0] = addr_q;
            end
            REG_WDATA:
            begin
                prdata[`EE_DATA_W-1:0] = wdata_q;
            end
            REG_STATUS:
            begin
                prdata[2:0] = status;
            end
            REG_RDATA:
            begin
                prdata[`EE_DATA_W-1:0] = rdata;
            end
            default:
            begin
                prdata = '0;  // CMD is write-only
            end
        endcase
    end

endmodule

// ==== eeprom_frame_seq.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_frame_seq
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    busy,
    output logic                    txn_start,
    output logic                    txn_end,
    output logic                    txn_nack,
    output logic                    op_is_read,
    output logic                    bit_valid,
    output eeprom_pkg::bit_req_t    bit_req,
    input  logic                    bit_done,
    input  eeprom_pkg::bit_rsp_t    bit_rsp
);

    localparam logic [8:0] ST_IDLE     = 9'b0_0000_0001;
    localparam logic [8:0] ST_START    = 9'b0_0000_0010;
    localparam logic [8:0] ST_CTRL_WR  = 9'b0_0000_0100;
    localparam logic [8:0] ST_ADDR_WR  = 9'b0_0000_1000;
    localparam logic [8:0] ST_DATA_WR  = 9'b0_0001_0000;
    localparam logic [8:0] ST_RESTART  = 9'b0_0010_0000;
    localparam logic [8:0] ST_CTRL_RD  = 9'b0_0100_0000;
    localparam logic [8:0] ST_DATA_RD  = 9'b0_1000_0000;
    localparam logic [8:0] ST_STOP     = 9'b1_0000_0000;

    logic [8:0]              state_q;
    logic [8:0]              state_d;
    logic                    nack_q;
    logic                    nack_d;
    eeprom_pkg::eeprom_cmd_t cmd_q;
    logic [7:0]              ctrl_byte;

    // device code, block select, r/w bit filled in per state
    assign ctrl_byte = {`EE_DEV_CODE, cmd_q.addr[`EE_ADDR_W-1:8], 1'b0};

    assign busy       = (state_q != ST_IDLE);
    assign bit_valid  = busy;
    assign txn_start  = (state_q == ST_IDLE) && cmd_valid;
    assign txn_end    = (state_q == ST_STOP) && bit_done;
    assign txn_nack   = nack_q;
    assign op_is_read = (cmd_q.op == eeprom_pkg::OP_READ);

    always_comb
    begin
        state_d = state_q;
        nack_d  = nack_q;
        if (state_q == ST_IDLE)
        begin
            if (cmd_valid)
            begin
                state_d = ST_START;
                nack_d  = 1'b0;
            end
        end
        else if (bit_done)
        begin
            case (state_q)
                ST_START:   state_d = ST_CTRL_WR;
                ST_CTRL_WR: state_d = ST_ADDR_WR;
                ST_ADDR_WR: state_d = op_is_read ? ST_RESTART : ST_DATA_WR;
                ST_DATA_WR: state_d = ST_STOP;
                ST_RESTART: state_d = ST_CTRL_RD;
                ST_CTRL_RD: state_d = ST_DATA_RD;
                ST_DATA_RD: state_d = ST_STOP;
                default:    state_d = ST_IDLE;  // stop done
            endcase
            // missing ack on any byte we sent cuts straight to stop
            if (bit_req.op == eeprom_pkg::BIT_WRITE && bit_rsp.nack_in)
            begin
                state_d = ST_STOP;
                nack_d  = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q <= ST_IDLE;
            nack_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            nack_q  <= nack_d;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (txn_start)
            cmd_q <= cmd;
    end

    always_comb
    begin
        bit_req.op      = eeprom_pkg::BIT_START;
        bit_req.data    = '0;
        bit_req.ack_out = 1'b0;
        case (state_q)
            ST_CTRL_WR:
            begin
                bit_req.op   = eeprom_pkg::BIT_WRITE;
                bit_req.data = ctrl_byte;
            end
            ST_ADDR_WR:
            begin
                bit_req.op   = eeprom_pkg::BIT_WRITE;
                bit_req.data = cmd_q.addr[7:0];
            end
            ST_DATA_WR:
            begin
                bit_req.op   = eeprom_pkg::BIT_WRITE;
                bit_req.data = cmd_q.wdata;
            end
            ST_CTRL_RD:
            begin
                bit_req.op   = eeprom_pkg::BIT_WRITE;
                bit_req.data = ctrl_byte | 8'h01;  // read bit
            end
            ST_DATA_RD:
            begin
                bit_req.op      = eeprom_pkg::BIT_READ;
                bit_req.ack_out = 1'b1;  // single byte, end with nack
            end
            ST_STOP:
            begin
                bit_req.op = eeprom_pkg::BIT_STOP;
            end
            default:
            begin
                bit_req.op = eeprom_pkg::BIT_START;  // start and restart
            end
        endcase
    end

endmodule

// ==== i2c_bit_engine.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 bit_valid,
    input  eeprom_pkg::bit_req_t bit_req,
    output logic                 bit_done,
    output eeprom_pkg::bit_rsp_t bit_rsp,
    output logic                 scl,
    output logic                 sda_pull,
    input  logic                 sda_in
);

    localparam int HALF = `EE_SCL_HALF;
    localparam int QTR  = HALF / 2;
    localparam int CW   = $clog2(2 * HALF);

    localparam logic [CW-1:0] CNT_MAX = CW'(2 * HALF - 1);
    localparam logic [CW-1:0] CNT_Q1  = CW'(QTR - 1);         // next cycle starts q1
    localparam logic [CW-1:0] CNT_HI  = CW'(HALF - 1);        // scl rises
    localparam logic [CW-1:0] CNT_Q3  = CW'(HALF + QTR - 1);  // mid high, sample point

    logic                  active_q;
    eeprom_pkg::bit_req_t  req_q;
    logic [CW-1:0]         cnt_q;
    logic [3:0]            slot_q;
    logic [`EE_DATA_W-1:0] tx_q;
    logic [`EE_DATA_W-1:0] rx_q;
    logic                  nack_q;
    logic                  scl_q;
    logic                  pull_q;
    logic                  is_byte;
    logic                  ack_slot;
    logic                  last_slot;
    logic                  pull_mid;
    logic                  pull_end;

    assign is_byte   = (req_q.op == eeprom_pkg::BIT_WRITE) || (req_q.op == eeprom_pkg::BIT_READ);
    assign ack_slot  = (slot_q == 4'(`EE_DATA_W));
    assign last_slot = is_byte ? ack_slot : 1'b1;

    // final slot ends a cycle early, the idle cycle finishes its high phase
    assign bit_done = active_q && last_slot && (cnt_q == CNT_MAX - 1'b1);

    assign bit_rsp.data    = rx_q;
    assign bit_rsp.nack_in = nack_q;
    assign scl             = scl_q;
    assign sda_pull        = pull_q;

    always_comb
    begin
        pull_mid = 1'b0;
        pull_end = 1'b0;
        case (req_q.op)
            eeprom_pkg::BIT_START:
            begin
                pull_mid = 1'b0;
                pull_end = 1'b1;  // sda falls with scl high
            end
            eeprom_pkg::BIT_STOP:
            begin
                pull_mid = 1'b1;
                pull_end = 1'b0;  // sda rises with scl high
            end
            eeprom_pkg::BIT_WRITE:
            begin
                pull_mid = ack_slot ? 1'b0 : !tx_q[`EE_DATA_W-1];
                pull_end = pull_mid;
            end
            default:
            begin
                pull_mid = ack_slot ? !req_q.ack_out : 1'b0;
                pull_end = pull_mid;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            slot_q   <= '0;
            scl_q    <= 1'b1;
            pull_q   <= 1'b0;
        end
        else if (!active_q)
        begin
            if (bit_valid)
            begin
                active_q <= 1'b1;
                cnt_q    <= '0;
                slot_q   <= '0;
                scl_q    <= 1'b0;
            end
        end
        else if (bit_done)
            active_q <= 1'b0;
        else if (cnt_q == CNT_MAX)
        begin
            cnt_q  <= '0;
            slot_q <= slot_q + 4'd1;
            scl_q  <= 1'b0;
        end
        else
        begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_Q1)
                pull_q <= pull_mid;
            if (cnt_q == CNT_HI)
                scl_q <= 1'b1;
            if (cnt_q == CNT_Q3)
                pull_q <= pull_end;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active_q && bit_valid)
        begin
            req_q <= bit_req;
            tx_q  <= bit_req.data;
        end
        else if (active_q)
        begin
            if (cnt_q == CNT_MAX)
                tx_q <= tx_q << 1;  // msb first
            if (cnt_q == CNT_Q3 && is_byte)
            begin
                if (ack_slot && req_q.op == eeprom_pkg::BIT_WRITE)
                    nack_q <= sda_in;  // released line reads 1
                else if (!ack_slot && req_q.op == eeprom_pkg::BIT_READ)
                    rx_q <= {rx_q[`EE_DATA_W-2:0], sda_in};
            end
        end
    end

endmodule

// ==== eeprom_result.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_result
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       txn_start,
    input  logic                       txn_end,
    input  logic                       txn_nack,
    input  logic                       op_is_read,
    input  eeprom_pkg::bit_rsp_t       bit_rsp,
    input  logic                       busy,
    output eeprom_pkg::eeprom_status_t status,
    output logic [`EE_DATA_W-1:0]      rdata
);

    logic done_q;
    logic nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else if (txn_start)
        begin
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else if (txn_end)
        begin
            done_q <= 1'b1;
            nack_q <= txn_nack;
        end
    end

    // last good read byte, survives writes and failed reads
    always_ff @(posedge CLK)
    begin
        if (txn_end && op_is_read && !txn_nack)
            rdata <= bit_rsp.data;
    end

    assign status.busy = busy;
    assign status.done = done_q;
    assign status.nack = nack_q;

endmodule

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_ctrl_top
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_pull,
    input  logic        sda_in
);

    logic                       busy;
    logic                       cmd_valid;
    eeprom_pkg::eeprom_cmd_t    cmd;
    eeprom_pkg::eeprom_status_t status;
    logic [`EE_DATA_W-1:0]      rdata;
    logic                       txn_start;
    logic                       txn_end;
    logic                       txn_nack;
    logic                       op_is_read;
    logic                       bit_valid;
    eeprom_pkg::bit_req_t       bit_req;
    logic                       bit_done;
    eeprom_pkg::bit_rsp_t       bit_rsp;

    eeprom_apb_regs u_regs
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .status    (status),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    eeprom_frame_seq u_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .txn_start  (txn_start),
        .txn_end    (txn_end),
        .txn_nack   (txn_nack),
        .op_is_read (op_is_read),
        .bit_valid  (bit_valid),
        .bit_req    (bit_req),
        .bit_done   (bit_done),
        .bit_rsp    (bit_rsp)
    );

    i2c_bit_engine u_bit
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .bit_valid (bit_valid),
        .bit_req   (bit_req),
        .bit_done  (bit_done),
        .bit_rsp   (bit_rsp),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

    eeprom_result u_result
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .txn_start  (txn_start),
        .txn_end    (txn_end),
        .txn_nack   (txn_nack),
        .op_is_read (op_is_read),
        .bit_rsp    (bit_rsp),
        .busy       (busy),
        .status     (status),
        .rdata      (rdata)
    );

endmodule

// ==== eeprom_model.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_pull
);

    localparam int IDLE = 0;
    localparam int RX   = 1;
    localparam int TX   = 2;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W)-1];
    logic [`EE_DATA_W-1:0] shift;
    logic [`EE_ADDR_W-1:0] ptr;  // internal word pointer
    int                    state;
    int                    bit_cnt;
    int                    byte_idx;
    logic                  in_ack;
    logic                  go_tx;

    initial
    begin
        state    = IDLE;
        sda_pull = 1'b0;
        in_ack   = 1'b0;
        go_tx    = 1'b0;
        bit_cnt  = 0;
        byte_idx = 0;
        ptr      = '0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state    = present ? RX : IDLE;
            bit_cnt  = 0;
            byte_idx = 0;
            in_ack   = 1'b0;
            go_tx    = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state    = IDLE;  // stop
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == RX && !in_ack)
        begin
            shift   = {shift[`EE_DATA_W-2:0], sda};
            bit_cnt = bit_cnt + 1;
        end
        else if (state == TX)
        begin
            if (bit_cnt == `EE_DATA_W)
            begin
                state = IDLE;  // master ack slot, single byte reads only
                ptr   = ptr + 1'b1;
            end
            else
                bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (state == RX && in_ack)
        begin
            sda_pull = 1'b0;
            in_ack   = 1'b0;
            bit_cnt  = 0;
            if (go_tx)
            begin
                state    = TX;
                shift    = mem[ptr];
                sda_pull = !shift[`EE_DATA_W-1];
            end
        end
        else if (state == RX && bit_cnt == `EE_DATA_W)
        begin
            in_ack   = 1'b1;
            sda_pull = 1'b1;
            if (byte_idx == 0)
            begin
                if (shift[7:4] != `EE_DEV_CODE)
                begin
                    state    = IDLE;  // not our device code
                    sda_pull = 1'b0;
                end
                else if (shift[0])
                    go_tx = 1'b1;
                else
                    ptr[`EE_ADDR_W-1:8] = shift[3:1];
            end
            else if (byte_idx == 1)
                ptr[7:0] = shift;
            else
            begin
                mem[ptr] = shift;
                ptr      = ptr + 1'b1;
            end
            byte_idx = byte_idx + 1;
        end
        else if (state == TX && bit_cnt < `EE_DATA_W)
            sda_pull = !shift[`EE_DATA_W-1-bit_cnt];
        else if (state == TX)
            sda_pull = 1'b0;  // let the master answer
    end

endmodule

// ==== tb_eeprom_ctrl.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module tb_eeprom_ctrl;

    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_WDATA  = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_STATUS = 5'h0C;
    localparam logic [4:0] REG_RDATA  = 5'h10;
    localparam int         POLL_LIMIT = 400;

    typedef struct packed
    {
        logic                  is_read;
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] data;
        logic                  present;
        logic                  exp_nack;
        logic                  rdata_known;
        logic [`EE_DATA_W-1:0] exp_rdata;
    } row_t;

    logic        CLK;
    logic        RESET;
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_pull;
    logic        ee_pull;
    logic        present;
    wire         sda;

    row_t                  rows[$];
    string                 names[$];
    logic [`EE_DATA_W-1:0] shadow [0:(1 << `EE_ADDR_W)-1];
    logic [`EE_DATA_W-1:0] last_rdata;
    logic                  rdata_known = 1'b0;
    logic [31:0]           rng;
    logic                  last_ready;  // pready seen in the latest access phase
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    assign sda = !(sda_pull || ee_pull);  // open drain with pull-up

    always #5 CLK = ~CLK;

    eeprom_ctrl_top DUT
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda)
    );

    eeprom_model u_eeprom
    (
        .scl      (scl),
        .sda      (sda),
        .present  (present),
        .sda_pull (ee_pull)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %s %s expected 0x%0h actual 0x%0h", test, what, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string test, input int errors_before);
        tests_run++;
        if (errors != errors_before)
        begin
            tests_failed++;
            $display("test %s failed", test);
        end
        else
            $display("test %s passed", test);
    endtask

    // setup then access phase, pready is tied high
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data, output logic err);
        @(negedge CLK);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        err        = pslverr;
        last_ready = pready;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge CLK);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        data       = prdata;
        last_ready = pready;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_for_done(input string test);
        logic [31:0] st;
        int          polls;
        logic        ok;
        ok    = 1'b0;
        polls = 0;
        while (!ok && polls < POLL_LIMIT)
        begin
            read_reg(REG_STATUS, st);
            ok = (st[1] === 1'b1);
            polls++;
        end
        if (!ok)
        begin
            $display("The transaction of test %s never finished.", test);
            errors++;
        end
    endtask

    // expected results follow the shadow copy of the EEPROM
    task automatic add_row(input string name, input logic is_read,
                           input logic [`EE_ADDR_W-1:0] addr,
                           input logic [`EE_DATA_W-1:0] data, input logic present_flag);
        row_t r;
        r.is_read  = is_read;
        r.addr     = addr;
        r.data     = data;
        r.present  = present_flag;
        r.exp_nack = !present_flag;
        if (present_flag && !is_read)
            shadow[addr] = data;
        if (present_flag && is_read)
        begin
            last_rdata  = shadow[addr];
            rdata_known = 1'b1;
        end
        r.rdata_known = rdata_known;
        r.exp_rdata   = last_rdata;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic run_row(input int i);
        row_t        r;
        string       nm;
        logic        err;
        logic [31:0] val;
        int          errors_before;
        r             = rows[i];
        nm            = names[i];
        errors_before = errors;
        present       = r.present;
        write_reg(REG_ADDR, 32'(r.addr), err);
        write_reg(REG_WDATA, 32'(r.data), err);
        write_reg(REG_CMD, r.is_read ? 32'd2 : 32'd1, err);
        if (err !== 1'b0)
            report_mismatch(nm, "pslverr", 32'd0, 32'(err));
        wait_for_done(nm);
        read_reg(REG_STATUS, val);
        if (val[2:0] !== {r.exp_nack, 2'b10})
            report_mismatch(nm, "status", {29'd0, r.exp_nack, 2'b10}, val);
        read_reg(REG_RDATA, val);
        if (r.rdata_known && val !== 32'(r.exp_rdata))
            report_mismatch(nm, "rdata", 32'(r.exp_rdata), val);
        finish_test(nm, errors_before);
    endtask

    initial
    begin
        logic        err;
        logic [31:0] val;
        int          errors_before;
        CLK     = 1'b0;
        RESET   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        present = 1'b1;
        rng     = 32'd74;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        errors_before = errors;
        @(negedge CLK);
        if (scl !== 1'b1)
            report_mismatch("reset_state", "scl", 32'd1, 32'(scl));
        if (sda_pull !== 1'b0)
            report_mismatch("reset_state", "sda_pull", 32'd0, 32'(sda_pull));
        if (pslverr !== 1'b0)
            report_mismatch("reset_state", "pslverr", 32'd0, 32'(pslverr));
        read_reg(REG_STATUS, val);
        if (val !== 32'd0)
            report_mismatch("reset_state", "status", 32'd0, val);
        finish_test("reset_state", errors_before);

        rng = xorshift32(rng);
        add_row("write_then_read_wr", 1'b0, 11'h05A, rng[7:0], 1'b1);
        add_row("write_then_read_rd", 1'b1, 11'h05A, 8'h00, 1'b1);
        // same low byte in every block, low bits of data tag the block
        for (int blk = 0; blk < 8; blk++)
        begin
            rng = xorshift32(rng);
            add_row($sformatf("cover_wr_blk%0d", blk), 1'b0, {blk[2:0], 8'h3C},
                    {rng[7:3], blk[2:0]}, 1'b1);
        end
        for (int blk = 0; blk < 8; blk++)
            add_row($sformatf("cover_rd_blk%0d", blk), 1'b1, {blk[2:0], 8'h3C}, 8'h00, 1'b1);
        rng = xorshift32(rng);
        add_row("noack_write", 1'b0, 11'h05A, rng[7:0], 1'b0);
        add_row("noack_read", 1'b1, 11'h23C, 8'h00, 1'b0);
        add_row("ack_restored", 1'b1, 11'h05A, 8'h00, 1'b1);

        for (int i = 0; i < rows.size(); i++)
            run_row(i);

        errors_before = errors;
        present       = 1'b1;
        write_reg(REG_ADDR, 32'h5A3, err);
        write_reg(REG_WDATA, 32'hC6, err);
        read_reg(REG_ADDR, val);
        if (val !== 32'h5A3)
            report_mismatch("apb_behavior", "addr readback", 32'h5A3, val);
        read_reg(REG_WDATA, val);
        if (val !== 32'hC6)
            report_mismatch("apb_behavior", "wdata readback", 32'hC6, val);
        read_reg(5'h14, val);
        if (val !== 32'd0)
            report_mismatch("apb_behavior", "unmapped read", 32'd0, val);
        write_reg(REG_CMD, 32'd3, err);
        read_reg(REG_STATUS, val);
        if (val[0] !== 1'b0)
            report_mismatch("apb_behavior", "busy after unknown cmd", 32'd0, 32'(val[0]));
        write_reg(REG_CMD, 32'd1, err);
        if (err !== 1'b0)
            report_mismatch("apb_behavior", "pslverr when idle", 32'd0, 32'(err));
        read_reg(REG_STATUS, val);
        if (val[2:0] !== 3'b001)
            report_mismatch("apb_behavior", "status while busy", 32'h1, val);
        write_reg(REG_CMD, 32'd2, err);
        if (err !== 1'b1)
            report_mismatch("apb_behavior", "pslverr when busy", 32'd1, 32'(err));
        if (last_ready !== 1'b1)
            report_mismatch("apb_behavior", "pready", 32'd1, 32'(last_ready));
        wait_for_done("apb_behavior");
        read_reg(REG_STATUS, val);
        if (val[2:0] !== 3'b010)
            report_mismatch("apb_behavior", "status", 32'h2, val);
        write_reg(REG_CMD, 32'd2, err);
        wait_for_done("apb_behavior");
        read_reg(REG_RDATA, val);
        if (val !== 32'hC6)
            report_mismatch("apb_behavior", "rdata after refused cmd", 32'hC6, val);
        finish_test("apb_behavior", errors_before);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
eeprom_pkg.sv
eeprom_apb_regs.sv
eeprom_frame_seq.sv
i2c_bit_engine.sv
eeprom_result.sv
eeprom_ctrl_top.sv
eeprom_model.sv
tb_eeprom_ctrl.sv

// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - .
    files:
      - eeprom_pkg.sv
      - eeprom_apb_regs.sv
      - eeprom_frame_seq.sv
      - i2c_bit_engine.sv
      - eeprom_result.sv
      - eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - eeprom_model.sv
      - tb_eeprom_ctrl.sv
